// ==== build.f ====
source/rename_pkg.sv
source/reorder_buffer.sv
source/free_list.sv
source/map_table.sv
source/recovery_fsm.sv
source/rename_core.sv
testbench/tb_rename_core.sv

// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - source/rename_pkg.sv
  - source/reorder_buffer.sv
  - source/free_list.sv
  - source/map_table.sv
  - source/recovery_fsm.sv
  - source/rename_core.sv
  - target: test
    files:
      - testbench/tb_rename_core.sv

// ==== testbench/tb_rename_core.sv ====
// self-checking testbench for the rename block
// drives random dispatch, retire and mispredict traffic and compares the
// outputs against a cycle model of free list, map table and reorder buffer

`default_nettype none
`timescale 1ns/1ps

module tb_rename_core;

  logic       clock;
  logic       reset;
  logic       dispatch;
  logic [4:0] dispatch_reg;
  logic       retire;
  logic       mispredict;
  logic [3:0] branch_idx;
  wire        stall;
  wire  [5:0] dispatch_tag;
  wire  [5:0] dispatch_old_tag;
  wire  [3:0] dispatch_idx;
  wire        retire_fire;
  wire  [5:0] retire_tag;
  wire        walking;

  // reference model state
  int     free_q[$];
  int     map_m[32];
  int     rob_reg[16];
  int     rob_new[16];
  int     rob_old[16];
  bit     rob_valid[16];
  int     head_m;
  int     tail_m;
  int     count_m;
  int     walk_left;
  integer seed;
  int     n_disp;
  int     n_ret;
  int     n_walk;
  int     n_full;
  int     n_idle_ret;

  rename_core i_rename_core (
    .clock            (clock),
    .reset            (reset),
    .dispatch         (dispatch),
    .dispatch_reg     (dispatch_reg),
    .retire           (retire),
    .mispredict       (mispredict),
    .branch_idx       (branch_idx),
    .stall            (stall),
    .dispatch_tag     (dispatch_tag),
    .dispatch_old_tag (dispatch_old_tag),
    .dispatch_idx     (dispatch_idx),
    .retire_fire      (retire_fire),
    .retire_tag       (retire_tag),
    .walking          (walking)
  );

  always #20 clock = ~clock;

  task automatic fail_run();
    $display("Checks failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      fail_run();
    end
  endtask

  // stall must cover the whole walk, and retire waits for it
  stall_during_walk : assert property (@(posedge clock) disable iff (reset)
    walking |-> stall)
    else begin
      $display("ERR stall got 0x%0h expected 0x1", stall);
      fail_run();
    end

  no_retire_in_walk : assert property (@(posedge clock) disable iff (reset)
    retire_fire |-> !walking)
    else begin
      $display("ERR retire_fire got 0x1 expected 0x0 during walk");
      fail_run();
    end

  // drive at the falling edge, check settled outputs, then step the model
  task automatic run_cycle(input logic d, input logic [4:0] rg, input logic r,
                           input logic m, input logic [3:0] bi);
    bit exp_walk;
    bit exp_stall;
    bit exp_disp;
    bit exp_mis;
    bit exp_ret;
    int idx;
    @(negedge clock);
    dispatch     = d;
    dispatch_reg = rg;
    retire       = r;
    mispredict   = m;
    branch_idx   = bi;
    #5;
    exp_walk  = (walk_left > 0);
    exp_stall = (count_m == 16) || (free_q.size() == 0) || exp_walk;
    exp_disp  = d && !exp_stall && !m;
    exp_mis   = m && rob_valid[bi] && !exp_walk;
    exp_ret   = r && rob_valid[head_m] && !exp_walk && !exp_mis;
    compare_value("walking", walking, exp_walk);
    compare_value("stall", stall, exp_stall);
    compare_value("dispatch_idx", dispatch_idx, tail_m);
    compare_value("dispatch_old_tag", dispatch_old_tag, map_m[rg]);
    if (free_q.size() > 0) begin
      compare_value("dispatch_tag", dispatch_tag, free_q[0]);
    end
    compare_value("retire_fire", retire_fire, exp_ret);
    if (exp_ret) begin
      compare_value("retire_tag", retire_tag, rob_old[head_m]);
    end
    if (count_m == 16) begin
      n_full++;
    end
    if (r && count_m == 0) begin
      n_idle_ret++;
    end
    // walk undoes the youngest entry
    if (exp_walk) begin
      idx = (tail_m + 15) % 16;
      map_m[rob_reg[idx]] = rob_old[idx];
      free_q.push_back(rob_new[idx]);
      rob_valid[idx] = 0;
      tail_m = idx;
      count_m--;
      walk_left--;
      n_walk++;
    end
    if (exp_disp) begin
      rob_reg[tail_m]   = rg;
      rob_new[tail_m]   = free_q.pop_front();
      rob_old[tail_m]   = map_m[rg];
      rob_valid[tail_m] = 1;
      map_m[rg] = rob_new[tail_m];
      tail_m  = (tail_m + 1) % 16;
      count_m++;
      n_disp++;
    end
    if (exp_ret) begin
      free_q.push_back(rob_old[head_m]);
      rob_valid[head_m] = 0;
      head_m = (head_m + 1) % 16;
      count_m--;
      n_ret++;
    end
    if (exp_mis) begin
      // occupancy less the entries up to and including the branch
      walk_left = count_m - ((int'(bi) - head_m + 16) % 16) - 1;
    end
  endtask

  initial begin
    int   k;
    logic [31:0] rnd;
    clock        = 1'b0;
    reset        = 1'b1;
    dispatch     = 1'b0;
    dispatch_reg = '0;
    retire       = 1'b0;
    mispredict   = 1'b0;
    branch_idx   = '0;
    seed         = 32'h5b2;
    // model matches the reset state
    for (k = 0; k < 32; k++) begin
      free_q.push_back(32 + k);
      map_m[k] = k;
    end
    for (k = 0; k < 16; k++) begin
      rob_valid[k] = 0;
    end
    head_m    = 0;
    tail_m    = 0;
    count_m   = 0;
    walk_left = 0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    // retire and mispredict on an empty buffer
    for (k = 0; k < 4; k++) begin
      rnd = $random(seed);
      run_cycle(1'b0, rnd[4:0], 1'b1, 1'b1, rnd[8:5]);
    end
    for (k = 0; k < 3000; k++) begin
      rnd = $random(seed);
      if (k < 60) begin
        // fill phase that reaches a full buffer
        run_cycle(rnd[3:0] != 0, rnd[8:4], rnd[12:9] == 0, 1'b0, rnd[16:13]);
      end else begin
        run_cycle(rnd[1:0] != 0, rnd[8:4], rnd[10:9] == 0, rnd[15:11] == 0,
                  rnd[19:16]);
      end
    end
    // let a pending walk drain
    k = 0;
    while (walking && k < 64) begin
      run_cycle(1'b0, 5'd0, 1'b0, 1'b0, 4'd0);
      k++;
    end
    if (walking) begin
      $display("recovery walk did not finish within 64 cycles");
      fail_run();
    end
    if (n_disp > 0 && n_ret > 0 && n_walk > 0 && n_full > 0 && n_idle_ret > 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("stimulus missed dispatch, retire, walk, full or empty retire cases");
      fail_run();
    end
  end

endmodule

`default_nettype wire

// ==== source/rename_core.sv ====
// top of the register rename and retirement block
// ties the reorder buffer, free list, map table and recovery sequencer
// together and forms the dispatch stall

`default_nettype none
`timescale 1ns/1ps

module rename_core (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   dispatch,
  input  wire rename_pkg::arch_reg_t dispatch_reg,
  input  wire                   retire,
  input  wire                   mispredict,
  input  wire rename_pkg::rob_idx_t  branch_idx,
  output logic                  stall,
  output rename_pkg::phys_tag_t dispatch_tag,
  output rename_pkg::phys_tag_t dispatch_old_tag,
  output rename_pkg::rob_idx_t  dispatch_idx,
  output logic                  retire_fire,
  output rename_pkg::phys_tag_t retire_tag,
  output logic                  walking
);

  import rename_pkg::*;

  logic       dispatch_fire;
  logic       rob_full;
  logic       free_empty;
  logic       mispredict_fire;
  rob_count_t squash_count;
  logic       walk_step;
  logic       push;
  phys_tag_t  push_tag;
  logic       restore;
  arch_reg_t  restore_reg;
  phys_tag_t  restore_tag;

  assign stall      = rob_full || free_empty || walking;
  // on a retire cycle the push port carries the head's old tag
  assign retire_tag = push_tag;

  reorder_buffer i_reorder_buffer (
    .clock           (clock),
    .reset           (reset),
    .dispatch        (dispatch),
    .dispatch_reg    (dispatch_reg),
    .new_tag         (dispatch_tag),
    .old_tag         (dispatch_old_tag),
    .retire          (retire),
    .mispredict      (mispredict),
    .branch_idx      (branch_idx),
    .walk_step       (walk_step),
    .stall_other     (free_empty || walking),
    .dispatch_fire   (dispatch_fire),
    .dispatch_idx    (dispatch_idx),
    .rob_full        (rob_full),
    .retire_fire     (retire_fire),
    .mispredict_fire (mispredict_fire),
    .squash_count    (squash_count),
    .push            (push),
    .push_tag        (push_tag),
    .restore         (restore),
    .restore_reg     (restore_reg),
    .restore_tag     (restore_tag)
  );

  free_list i_free_list (
    .clock      (clock),
    .reset      (reset),
    .pop        (dispatch_fire),
    .push       (push),
    .push_tag   (push_tag),
    .free_tag   (dispatch_tag),
    .free_empty (free_empty)
  );

  map_table i_map_table (
    .clock       (clock),
    .reset       (reset),
    .lookup_reg  (dispatch_reg),
    .write       (dispatch_fire),
    .write_tag   (dispatch_tag),
    .restore     (restore),
    .restore_reg (restore_reg),
    .restore_tag (restore_tag),
    .lookup_tag  (dispatch_old_tag)
  );

  recovery_fsm i_recovery_fsm (
    .clock           (clock),
    .reset           (reset),
    .mispredict_fire (mispredict_fire),
    .squash_count    (squash_count),
    .walk_step       (walk_step),
    .walking         (walking)
  );

endmodule

`default_nettype wire

// ==== source/recovery_fsm.sv ====
// sequencer for branch recovery
// loads the squash count on an accepted mispredict and then issues one
// walk step per cycle until every younger entry has been unwound

`default_nettype none
`timescale 1ns/1ps

module recovery_fsm (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    mispredict_fire,
  input  wire rename_pkg::rob_count_t squash_count,
  output logic                   walk_step,
  output logic                   walking
);

  import rename_pkg::*;

  typedef enum logic {
    st_idle,
    st_walk
  } state_t;

  state_t     state;
  rob_count_t remaining;

  assign walking   = (state == st_walk);
  assign walk_step = walking && (remaining != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= st_idle;
      remaining <= '0;
    end else begin
      unique case (state)
        st_idle: begin
          // nothing to undo when the branch is the youngest entry
          if (mispredict_fire && squash_count != '0) begin
            state     <= st_walk;
            remaining <= squash_count;
          end
        end
        st_walk: begin
          remaining <= remaining - 1'b1;
          // last step, back to idle
          if (remaining == rob_count_t'(1)) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  // the buffer blocks new mispredicts for the whole walk
  a_no_nested : assert property (@(posedge clock) disable iff (reset)
    mispredict_fire |-> !walking)
    else $error("mispredict accepted during a recovery walk");

endmodule

`default_nettype wire

// ==== source/map_table.sv ====
// speculative map from architectural registers to physical tags
// dispatch overwrites the destination mapping, the recovery walk puts
// the previous tag back one register per cycle

`default_nettype none
`timescale 1ns/1ps

module map_table (
  input  wire                   clock,
  input  wire                   reset,
  input  wire rename_pkg::arch_reg_t lookup_reg,
  input  wire                   write,
  input  wire rename_pkg::phys_tag_t write_tag,
  input  wire                   restore,
  input  wire rename_pkg::arch_reg_t restore_reg,
  input  wire rename_pkg::phys_tag_t restore_tag,
  output rename_pkg::phys_tag_t lookup_tag
);

  import rename_pkg::*;

  phys_tag_t map_q [num_arch];

  // current mapping, read in the dispatch cycle
  assign lookup_tag = map_q[lookup_reg];

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity mapping out of reset
      for (int i = 0; i < num_arch; i++) begin
        map_q[i] <= phys_tag_t'(i);
      end
    end else if (write) begin
      map_q[lookup_reg] <= write_tag;
    end else if (restore) begin
      map_q[restore_reg] <= restore_tag;
    end
  end

  // dispatch is stalled for the whole walk
  a_write_excl : assert property (@(posedge clock) disable iff (reset)
    !(write && restore))
    else $error("dispatch write and recovery restore in the same cycle");

endmodule

`default_nettype wire

// ==== source/free_list.sv ====
// FIFO of free physical tags for the rename block
// starts full with the tags above the architectural range, pops one tag
// per dispatch and takes freed tags back through a single push port

`default_nettype none
`timescale 1ns/1ps

module free_list (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   pop,
  input  wire                   push,
  input  wire rename_pkg::phys_tag_t push_tag,
  output rename_pkg::phys_tag_t free_tag,
  output logic                  free_empty
);

  import rename_pkg::*;

  phys_tag_t                     slots [num_free];
  logic [$clog2(num_free)-1:0]   rd_ptr;
  logic [$clog2(num_free)-1:0]   wr_ptr;
  logic [$clog2(num_free+1)-1:0] count;

  // oldest free tag sits at the read pointer
  assign free_tag   = slots[rd_ptr];
  assign free_empty = (count == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= ($clog2(num_free+1))'(num_free);
      // tags num_arch and up, in order
      for (int i = 0; i < num_free; i++) begin
        slots[i] <= phys_tag_t'(num_arch + i);
      end
    end else begin
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push) begin
        slots[wr_ptr] <= push_tag;
        wr_ptr        <= wr_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // tags are conserved, so the queue never under- or overflows
  a_bounds : assert property (@(posedge clock) disable iff (reset)
    !(pop && free_empty) &&
    !(push && !pop && count == ($clog2(num_free+1))'(num_free)))
    else $error("free list popped while empty or pushed past capacity");

endmodule

`default_nettype wire

// ==== source/reorder_buffer.sv ====
// circular reorder buffer for the rename block
// dispatch writes at the tail, retire frees the head, and after a
// mispredict the recovery walk unwinds the tail one entry per cycle

`default_nettype none
`timescale 1ns/1ps

module reorder_buffer (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    dispatch,
  input  wire rename_pkg::arch_reg_t  dispatch_reg,
  input  wire rename_pkg::phys_tag_t  new_tag,
  input  wire rename_pkg::phys_tag_t  old_tag,
  input  wire                    retire,
  input  wire                    mispredict,
  input  wire rename_pkg::rob_idx_t   branch_idx,
  input  wire                    walk_step,
  input  wire                    stall_other,
  output logic                   dispatch_fire,
  output rename_pkg::rob_idx_t   dispatch_idx,
  output logic                   rob_full,
  output logic                   retire_fire,
  output logic                   mispredict_fire,
  output rename_pkg::rob_count_t squash_count,
  output logic                   push,
  output rename_pkg::phys_tag_t  push_tag,
  output logic                   restore,
  output rename_pkg::arch_reg_t  restore_reg,
  output rename_pkg::phys_tag_t  restore_tag
);

  import rename_pkg::*;

  logic [num_rob-1:0] valid;
  arch_reg_t          reg_q [num_rob];
  phys_tag_t          new_q [num_rob];
  phys_tag_t          old_q [num_rob];
  rob_idx_t           head;
  rob_idx_t           tail;
  rob_idx_t           tail_prev;
  rob_count_t         count;
  rob_idx_t           squash_span;
  rob_idx_t           branch_offset;

  assign tail_prev     = tail - 1'b1;
  assign squash_span   = tail - branch_idx - 1'b1;
  assign branch_offset = branch_idx - head;

  // accept conditions are resolved once here
  assign rob_full        = (count == rob_count_t'(num_rob));
  assign dispatch_fire   = dispatch && !rob_full && !stall_other && !mispredict;
  assign mispredict_fire = mispredict && valid[branch_idx] && !walk_step;
  // a walk or a fresh mispredict holds the head
  assign retire_fire     = retire && valid[head] && !walk_step && !mispredict_fire;

  assign dispatch_idx = tail;
  // entries younger than the branch up to the tail
  assign squash_count = {1'b0, squash_span};

  // walk step undoes the youngest entry
  assign restore     = walk_step;
  assign restore_reg = reg_q[tail_prev];
  assign restore_tag = old_q[tail_prev];

  // single free-list port since retire and walk never overlap
  assign push     = retire_fire || walk_step;
  assign push_tag = walk_step ? new_q[tail_prev] : old_q[head];

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      valid <= '0;
    end else begin
      if (dispatch_fire) begin
        valid[tail] <= 1'b1;
        tail        <= tail + 1'b1;
      end
      if (retire_fire) begin
        valid[head] <= 1'b0;
        head        <= head + 1'b1;
      end
      if (walk_step) begin
        valid[tail_prev] <= 1'b0;
        tail             <= tail_prev;
      end
      count <= count + rob_count_t'(dispatch_fire) - rob_count_t'(retire_fire)
               - rob_count_t'(walk_step);
    end
  end

  // entry payload
  always_ff @(posedge clock) begin
    if (dispatch_fire) begin
      reg_q[tail] <= dispatch_reg;
      new_q[tail] <= new_tag;
      old_q[tail] <= old_tag;
    end
  end

  // the tail slot is free whenever a dispatch lands
  a_no_write_full : assert property (@(posedge clock) disable iff (reset)
    dispatch_fire |-> !valid[tail])
    else $error("dispatch written into a full reorder buffer");

  // an accepted branch lies between head and tail
  a_branch_in_window : assert property (@(posedge clock) disable iff (reset)
    mispredict_fire |-> ({1'b0, branch_offset} < count))
    else $error("mispredict accepted on a stale index");

endmodule

`default_nettype wire

// ==== source/rename_pkg.sv ====
// shared sizes and types for the register rename block
// modules name these types in their port lists and import the package
// in their bodies for everything else

`default_nettype none

package rename_pkg;

  // register file and buffer sizes
  localparam int num_arch = 32;
  localparam int num_phys = 64;
  localparam int num_rob  = 16;

  // tags not mapped after reset sit in the free list
  localparam int num_free = num_phys - num_arch;

  // architectural register number
  typedef logic [$clog2(num_arch)-1:0] arch_reg_t;

  // physical register tag
  typedef logic [$clog2(num_phys)-1:0] phys_tag_t;

  // reorder buffer slot index
  typedef logic [$clog2(num_rob)-1:0] rob_idx_t;

  // occupancy or squash count, one bit wider than an index
  typedef logic [$clog2(num_rob):0] rob_count_t;

endpackage

`default_nettype wire
